//--- global_buffer_pkg.sv
package global_buffer_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // array size and configuration address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int NUM_TILES           = 3;
    localparam int TILE_SEL_ADDR_WIDTH = 4;
    localparam int CFG_ADDR_WIDTH      = 11;
    localparam int CFG_DATA_WIDTH      = 32;

    // the tile field sits at the top of the address and the register number
    // below it, with the two byte offset bits left unused.
    localparam int CFG_TILE_SEL_LSB  = CFG_ADDR_WIDTH - TILE_SEL_ADDR_WIDTH;
    localparam int CFG_REG_SEL_LSB   = 2;
    localparam int CFG_REG_SEL_WIDTH = CFG_TILE_SEL_LSB - CFG_REG_SEL_LSB;

    localparam int QUEUE_DEPTH         = 4;
    localparam int QUEUE_IDX_WIDTH     = $clog2(QUEUE_DEPTH);
    localparam int GLB_ADDR_WIDTH      = 16;
    localparam int MAX_NUM_WORDS_WIDTH = 12;

    // register numbers inside one tile.
    localparam logic [CFG_REG_SEL_WIDTH-1:0] REG_TILE_CTRL          = 'd0;
    localparam logic [CFG_REG_SEL_WIDTH-1:0] REG_STORE_DMA_CTRL     = 'd1;
    localparam logic [CFG_REG_SEL_WIDTH-1:0] REG_STORE_DMA_HDR_BASE = 'd2;
    // each header takes two registers.
    localparam logic [CFG_REG_SEL_WIDTH-1:0] NUM_HDR_REGS = CFG_REG_SEL_WIDTH'(2 * QUEUE_DEPTH);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bridge read timeout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int RD_TIMEOUT   = 64;
    localparam int RD_CNT_WIDTH = $clog2(RD_TIMEOUT);
    localparam logic [RD_CNT_WIDTH-1:0] RD_CNT_LAST = RD_CNT_WIDTH'(RD_TIMEOUT - 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shared types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                           valid;
        logic [GLB_ADDR_WIDTH-1:0]      start_addr;
        logic [MAX_NUM_WORDS_WIDTH-1:0] num_words;
    } dma_header_t;

    // configuration request, travels from east to west along the chain.
    typedef struct packed {
        logic                      wr_en;
        logic [CFG_ADDR_WIDTH-1:0] wr_addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
        logic                      rd_en;
        logic [CFG_ADDR_WIDTH-1:0] rd_addr;
    } cfg_req_t;

    // read response, travels back from west to east.
    typedef struct packed {
        logic [CFG_DATA_WIDTH-1:0] rd_data;
        logic                      rd_data_valid;
    } cfg_rsp_t;

    // the state one tile exports to its buffer and DMA logic.
    typedef struct packed {
        logic                          tile_is_start;
        logic                          tile_is_end;
        logic                          store_dma_on;
        logic                          store_dma_auto_on;
        dma_header_t [QUEUE_DEPTH-1:0] store_dma_header;
    } tile_cfg_t;

endpackage

//--- glb_cfg_apb_bridge.sv
`timescale 1ns/1ns

module glb_cfg_apb_bridge (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         psel,
    input  logic                                         penable,
    input  logic                                         pwrite,
    input  logic [global_buffer_pkg::CFG_ADDR_WIDTH-1:0] paddr,
    input  logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] pwdata,
    output logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] prdata,
    output logic                                         pready,
    output logic                                         pslverr,
    output global_buffer_pkg::cfg_req_t                  cfg_req,
    input  global_buffer_pkg::cfg_rsp_t                  cfg_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUED,
        ST_WAITING
    } state_t;

    state_t state;
    state_t state_next;

    logic access_start;
    logic wr_start;
    logic rd_start;
    logic rd_done;
    logic rd_err;
    logic rd_timeout;
    logic [global_buffer_pkg::RD_CNT_WIDTH-1:0] rd_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transfer start and APB outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a transfer starts in its first access cycle. The cycle in which a read
    // completes is still an access cycle, so rd_done keeps it from counting twice.
    assign access_start = (state == ST_IDLE) && psel && penable && !rd_done;
    assign wr_start     = access_start && pwrite;
    assign rd_start     = access_start && !pwrite;

    // writes are posted and finish with no wait state.
    assign pready  = rd_done | wr_start;
    assign pslverr = rd_err;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (rd_start) begin
                    state_next = ST_ISSUED;
                end
            end
            ST_ISSUED: begin
                // the request pulse is on the bus in this cycle.
                state_next = ST_WAITING;
            end
            ST_WAITING: begin
                if (cfg_rsp.rd_data_valid || rd_timeout) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // counts the cycles spent waiting for an answer.
    assign rd_timeout = (rd_cnt == global_buffer_pkg::RD_CNT_LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_cnt <= '0;
        end else if (state != ST_WAITING) begin
            rd_cnt <= '0;
        end else begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request issue and read completion
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one request pulse per APB transfer, one cycle after the access phase begins.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_req <= '0;
        end else begin
            cfg_req.wr_en <= wr_start;
            cfg_req.rd_en <= rd_start;
            if (access_start) begin
                cfg_req.wr_addr <= paddr;
                cfg_req.wr_data <= pwdata;
                cfg_req.rd_addr <= paddr;
            end
        end
    end

    // a response ends the read with its data. No answer in time means the
    // tile does not exist, so the read ends with an error and zero data.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_done <= 1'b0;
            rd_err  <= 1'b0;
            prdata  <= '0;
        end else begin
            rd_done <= 1'b0;
            rd_err  <= 1'b0;
            if (state == ST_WAITING) begin
                if (cfg_rsp.rd_data_valid) begin
                    rd_done <= 1'b1;
                    prdata  <= cfg_rsp.rd_data;
                end else if (rd_timeout) begin
                    rd_done <= 1'b1;
                    rd_err  <= 1'b1;
                    prdata  <= '0;
                end
            end
        end
    end

endmodule

//--- glb_tile_cfg.sv
`timescale 1ns/1ns

module glb_tile_cfg #(
    parameter int TILE_ID = 0
) (
    input  logic                         clk,
    input  logic                         reset,
    input  global_buffer_pkg::cfg_req_t  req_east,
    output global_buffer_pkg::cfg_rsp_t  rsp_east,
    output global_buffer_pkg::cfg_req_t  req_west,
    input  global_buffer_pkg::cfg_rsp_t  rsp_west,
    output global_buffer_pkg::tile_cfg_t tile_cfg
);

    // decoded form of one configuration address.
    typedef struct packed {
        logic                                          tile_hit;
        logic                                          is_tile_ctrl;
        logic                                          is_dma_ctrl;
        logic                                          is_hdr;
        logic [global_buffer_pkg::QUEUE_IDX_WIDTH-1:0] hdr_idx;
        logic                                          hdr_cnt;
    } reg_dec_t;

    reg_dec_t wr_dec;
    reg_dec_t rd_dec;

    logic wr_local;
    logic rd_local;

    global_buffer_pkg::dma_header_t           rd_hdr;
    logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] rd_data_local;
    global_buffer_pkg::cfg_req_t              req_west_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // headers start at register 2 and alternate between {start_addr, valid}
    // and num_words. Register numbers below the base wrap to a large offset,
    // so the single compare against NUM_HDR_REGS covers both ends.
    function automatic reg_dec_t decode_addr(
        input logic [global_buffer_pkg::CFG_ADDR_WIDTH-1:0] addr
    );
        logic [global_buffer_pkg::TILE_SEL_ADDR_WIDTH-1:0] tile_sel;
        logic [global_buffer_pkg::CFG_REG_SEL_WIDTH-1:0]   reg_sel;
        logic [global_buffer_pkg::CFG_REG_SEL_WIDTH-1:0]   hdr_off;
        reg_dec_t                                          dec;

        tile_sel = addr[global_buffer_pkg::CFG_TILE_SEL_LSB +:
                        global_buffer_pkg::TILE_SEL_ADDR_WIDTH];
        reg_sel  = addr[global_buffer_pkg::CFG_REG_SEL_LSB +:
                        global_buffer_pkg::CFG_REG_SEL_WIDTH];
        hdr_off  = reg_sel - global_buffer_pkg::REG_STORE_DMA_HDR_BASE;

        dec.tile_hit     = (tile_sel == TILE_ID[global_buffer_pkg::TILE_SEL_ADDR_WIDTH-1:0]);
        dec.is_tile_ctrl = (reg_sel == global_buffer_pkg::REG_TILE_CTRL);
        dec.is_dma_ctrl  = (reg_sel == global_buffer_pkg::REG_STORE_DMA_CTRL);
        dec.is_hdr       = (hdr_off < global_buffer_pkg::NUM_HDR_REGS);
        dec.hdr_idx      = hdr_off[global_buffer_pkg::QUEUE_IDX_WIDTH:1];
        dec.hdr_cnt      = hdr_off[0];
        return dec;
    endfunction

    assign wr_dec = decode_addr(req_east.wr_addr);
    assign rd_dec = decode_addr(req_east.rd_addr);

    assign wr_local = req_east.wr_en && wr_dec.tile_hit;
    assign rd_local = req_east.rd_en && rd_dec.tile_hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // configuration registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // unmapped register numbers match none of the cases and the write is lost.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tile_cfg <= '0;
        end else if (wr_local) begin
            if (wr_dec.is_tile_ctrl) begin
                tile_cfg.tile_is_start <= req_east.wr_data[0];
                tile_cfg.tile_is_end   <= req_east.wr_data[1];
            end
            if (wr_dec.is_dma_ctrl) begin
                tile_cfg.store_dma_on      <= req_east.wr_data[0];
                tile_cfg.store_dma_auto_on <= req_east.wr_data[1];
            end
            if (wr_dec.is_hdr && !wr_dec.hdr_cnt) begin
                tile_cfg.store_dma_header[wr_dec.hdr_idx].valid <= req_east.wr_data[0];
                tile_cfg.store_dma_header[wr_dec.hdr_idx].start_addr <=
                    req_east.wr_data[global_buffer_pkg::GLB_ADDR_WIDTH:1];
            end
            if (wr_dec.is_hdr && wr_dec.hdr_cnt) begin
                tile_cfg.store_dma_header[wr_dec.hdr_idx].num_words <=
                    req_east.wr_data[global_buffer_pkg::MAX_NUM_WORDS_WIDTH-1:0];
            end
        end
    end

    // read data for this tile, zero extended to the bus width.
    assign rd_hdr = tile_cfg.store_dma_header[rd_dec.hdr_idx];

    always_comb begin
        rd_data_local = '0;
        if (rd_dec.is_tile_ctrl) begin
            rd_data_local[1:0] = {tile_cfg.tile_is_end, tile_cfg.tile_is_start};
        end else if (rd_dec.is_dma_ctrl) begin
            rd_data_local[1:0] = {tile_cfg.store_dma_auto_on, tile_cfg.store_dma_on};
        end else if (rd_dec.is_hdr) begin
            if (rd_dec.hdr_cnt) begin
                rd_data_local[global_buffer_pkg::MAX_NUM_WORDS_WIDTH-1:0] = rd_hdr.num_words;
            end else begin
                rd_data_local[global_buffer_pkg::GLB_ADDR_WIDTH:0] =
                    {rd_hdr.start_addr, rd_hdr.valid};
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // east to west request router
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a request for another tile moves one hop west per cycle.
    // Requests kept here do not go further.
    always_comb begin
        req_west_next       = req_east;
        req_west_next.wr_en = req_east.wr_en && !wr_dec.tile_hit;
        req_west_next.rd_en = req_east.rd_en && !rd_dec.tile_hit;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_west <= '0;
        end else begin
            req_west <= req_west_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // west to east response return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // only one read is in flight, so a local answer and a forwarded one
    // never arrive together. The local answer still takes precedence.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_east <= '0;
        end else if (rd_local) begin
            rsp_east.rd_data       <= rd_data_local;
            rsp_east.rd_data_valid <= 1'b1;
        end else if (rsp_west.rd_data_valid) begin
            rsp_east <= rsp_west;
        end else begin
            rsp_east.rd_data_valid <= 1'b0;
        end
    end

endmodule

//--- glb_cfg_top.sv
`timescale 1ns/1ns

module glb_cfg_top (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         psel,
    input  logic                                         penable,
    input  logic                                         pwrite,
    input  logic [global_buffer_pkg::CFG_ADDR_WIDTH-1:0] paddr,
    input  logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] pwdata,
    output logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] prdata,
    output logic                                         pready,
    output logic                                         pslverr,
    output global_buffer_pkg::tile_cfg_t                 tile_cfg [global_buffer_pkg::NUM_TILES]
);

    // entry i of each chain is the east port of tile i.
    global_buffer_pkg::cfg_req_t req_chain [global_buffer_pkg::NUM_TILES];
    global_buffer_pkg::cfg_rsp_t rsp_chain [global_buffer_pkg::NUM_TILES];

    glb_cfg_apb_bridge u_bridge (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg_req (req_chain[0]),
        .cfg_rsp (rsp_chain[0])
    );

    for (genvar i = 0; i < global_buffer_pkg::NUM_TILES; i++) begin : g_tile
        if (i < global_buffer_pkg::NUM_TILES - 1) begin : g_link
            glb_tile_cfg #(.TILE_ID(i)) u_tile (
                .clk      (clk),
                .reset    (reset),
                .req_east (req_chain[i]),
                .rsp_east (rsp_chain[i]),
                .req_west (req_chain[i+1]),
                .rsp_west (rsp_chain[i+1]),
                .tile_cfg (tile_cfg[i])
            );
        end else begin : g_end
            // the far end of the chain has no neighbour to the west.
            glb_tile_cfg #(.TILE_ID(i)) u_tile (
                .clk      (clk),
                .reset    (reset),
                .req_east (req_chain[i]),
                .rsp_east (rsp_chain[i]),
                .req_west (),
                .rsp_west ('0),
                .tile_cfg (tile_cfg[i])
            );
        end
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset is released on a falling edge, away from the flops' sampling edge.
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- tb_cfg_checker.sv
`timescale 1ns/1ns

module tb_cfg_checker (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         psel,
    input  logic                                         penable,
    input  logic                                         pwrite,
    input  logic [global_buffer_pkg::CFG_ADDR_WIDTH-1:0] paddr,
    input  logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] pwdata,
    input  logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] prdata,
    input  logic                                         pready,
    input  logic                                         pslverr,
    input  global_buffer_pkg::tile_cfg_t                 tile_cfg [global_buffer_pkg::NUM_TILES],
    output int                                           read_errors,
    output int                                           ready_errors,
    output int                                           cfg_errors,
    output int                                           reads_checked
);

    // register image of every tile with each entry masked to its fields.
    logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] regs
        [global_buffer_pkg::NUM_TILES][2**global_buffer_pkg::CFG_REG_SEL_WIDTH];
    int cycle;
    int access_cycles;
    int settle [global_buffer_pkg::NUM_TILES];
    bit flagged [global_buffer_pkg::NUM_TILES];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map of one tile
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // registers 0 and 1 hold two flag bits each, then each header takes
    // {start_addr, valid} followed by num_words.
    function automatic logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] field_mask(
        input int reg_num
    );
        logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] mask;
        mask = '0;
        if (reg_num < 2) begin
            mask[1:0] = 2'b11;
        end else if (reg_num < 2 + 2 * global_buffer_pkg::QUEUE_DEPTH) begin
            if (reg_num % 2 == 0) begin
                mask[global_buffer_pkg::GLB_ADDR_WIDTH:0] = '1;
            end else begin
                mask[global_buffer_pkg::MAX_NUM_WORDS_WIDTH-1:0] = '1;
            end
        end
        return mask;
    endfunction

    function automatic global_buffer_pkg::tile_cfg_t expected_cfg(input int t);
        global_buffer_pkg::tile_cfg_t cfg;
        cfg.tile_is_start     = regs[t][0][0];
        cfg.tile_is_end       = regs[t][0][1];
        cfg.store_dma_on      = regs[t][1][0];
        cfg.store_dma_auto_on = regs[t][1][1];
        for (int h = 0; h < global_buffer_pkg::QUEUE_DEPTH; h++) begin
            cfg.store_dma_header[h].valid      = regs[t][2 + 2 * h][0];
            cfg.store_dma_header[h].start_addr =
                regs[t][2 + 2 * h][global_buffer_pkg::GLB_ADDR_WIDTH:1];
            cfg.store_dma_header[h].num_words  =
                regs[t][3 + 2 * h][global_buffer_pkg::MAX_NUM_WORDS_WIDTH-1:0];
        end
        return cfg;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB transfers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin : watch_apb
        int tile;
        int reg_num;
        logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] exp_data;
        logic exp_err;
        cycle++;
        if (reset) begin
            foreach (regs[t, r]) begin
                regs[t][r] = '0;
            end
            access_cycles = 0;
        end else begin
            // writes are posted, so pready comes in the first access cycle.
            if (psel && penable && pwrite && access_cycles == 0 && pready !== 1'b1) begin
                $display("FAIL time=%0t signal=pready expected=1 actual=%b",
                         $time, pready);
                ready_errors++;
            end
            if (psel && penable && !pready) begin
                access_cycles++;
            end else begin
                access_cycles = 0;
            end
            if (psel && penable && pready) begin
                tile    = int'(paddr[global_buffer_pkg::CFG_TILE_SEL_LSB +:
                                 global_buffer_pkg::TILE_SEL_ADDR_WIDTH]);
                reg_num = int'(paddr[global_buffer_pkg::CFG_REG_SEL_LSB +:
                                 global_buffer_pkg::CFG_REG_SEL_WIDTH]);
                exp_err  = !pwrite && (tile >= global_buffer_pkg::NUM_TILES);
                exp_data = '0;
                if (tile < global_buffer_pkg::NUM_TILES) begin
                    if (pwrite) begin
                        regs[tile][reg_num] = pwdata & field_mask(reg_num);
                        // tile k sees the write k+1 cycles after this edge.
                        settle[tile] = cycle + tile + 1;
                    end else begin
                        exp_data = regs[tile][reg_num];
                    end
                end
                if (!pwrite) begin
                    reads_checked++;
                    if (prdata !== exp_data) begin
                        $display("FAIL time=%0t signal=prdata expected=%h actual=%h",
                                 $time, exp_data, prdata);
                        read_errors++;
                    end
                end
                if (pslverr !== exp_err) begin
                    $display("FAIL time=%0t signal=pslverr expected=%b actual=%b",
                             $time, exp_err, pslverr);
                    read_errors++;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // exported tile state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // flagged marks a tile whose mismatch is already counted and clears once it matches.
    always @(negedge clk) begin : watch_cfg
        global_buffer_pkg::tile_cfg_t exp_cfg;
        if (!reset) begin
            for (int t = 0; t < global_buffer_pkg::NUM_TILES; t++) begin
                exp_cfg = expected_cfg(t);
                if (cycle >= settle[t] && tile_cfg[t] !== exp_cfg) begin
                    if (!flagged[t]) begin
                        $display("FAIL time=%0t signal=tile_cfg[%0d] expected=%h actual=%h",
                                 $time, t, exp_cfg, tile_cfg[t]);
                        cfg_errors++;
                    end
                    flagged[t] = 1'b1;
                end else begin
                    flagged[t] = 1'b0;
                end
            end
        end
    end

endmodule

//--- tb_glb_cfg.sv
`timescale 1ns/1ns

module tb_glb_cfg;

    logic clk;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [global_buffer_pkg::CFG_ADDR_WIDTH-1:0] paddr;
    logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] pwdata;
    logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] prdata;
    logic pready;
    logic pslverr;
    global_buffer_pkg::tile_cfg_t tile_cfg [global_buffer_pkg::NUM_TILES];

    int seed;
    int timeouts;
    int read_errors;
    int ready_errors;
    int cfg_errors;
    int reads_checked;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .reset (reset)
    );

    glb_cfg_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .tile_cfg (tile_cfg)
    );

    tb_cfg_checker u_chk (
        .clk           (clk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .tile_cfg      (tile_cfg),
        .read_errors   (read_errors),
        .ready_errors  (ready_errors),
        .cfg_errors    (cfg_errors),
        .reads_checked (reads_checked)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // pready is taken at the rising edge that ends the access phase.
    task automatic wait_ready(output bit ok);
        ok = 1'b0;
        for (int n = 0; n < global_buffer_pkg::RD_TIMEOUT + 20; n++) begin
            @(posedge clk);
            if (pready) begin
                ok = 1'b1;
                break;
            end
        end
    endtask

    task automatic apb_transfer(input logic write, input int tile, input int reg_num,
                                input logic [global_buffer_pkg::CFG_DATA_WIDTH-1:0] data);
        logic [global_buffer_pkg::TILE_SEL_ADDR_WIDTH-1:0] tile_sel;
        logic [global_buffer_pkg::CFG_REG_SEL_WIDTH-1:0]   reg_sel;
        bit ok;
        tile_sel = tile[global_buffer_pkg::TILE_SEL_ADDR_WIDTH-1:0];
        reg_sel  = reg_num[global_buffer_pkg::CFG_REG_SEL_WIDTH-1:0];
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = {tile_sel, reg_sel, 2'b00};
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        wait_ready(ok);
        if (!ok) begin
            $display("timeout: no pready for the %s of tile %0d register %0d at %0t",
                     write ? "write" : "read", tile, reg_num, $time);
            timeouts++;
        end
    endtask

    task automatic idle_bus(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    // reads every register number of every tile id, mapped or not.
    task automatic read_all();
        for (int t = 0; t < 5 && timeouts == 0; t++) begin
            for (int r = 0; r < 12 && timeouts == 0; r++) begin
                apb_transfer(1'b0, t, r, '0);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and report
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int tile;
        int reg_num;
        seed     = 86;
        timeouts = 0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        for (int n = 0; n < 64 && reset !== 1'b0; n++) begin
            @(posedge clk);
        end
        if (reset !== 1'b0) begin
            $display("reset was never released");
            timeouts++;
        end
        read_all();
        for (int n = 0; n < 400 && timeouts == 0; n++) begin
            tile    = $unsigned($random(seed)) % 5;
            reg_num = $unsigned($random(seed)) % 12;
            apb_transfer(1'($random(seed)), tile, reg_num, $random(seed));
            idle_bus($unsigned($random(seed)) % 3);
        end
        idle_bus(1);
        read_all();
        idle_bus(4);
        $display("errors: read %0d, pready %0d, tile_cfg %0d, timeout %0d, reads checked %0d",
                 read_errors, ready_errors, cfg_errors, timeouts, reads_checked);
        if (read_errors == 0 && ready_errors == 0 && cfg_errors == 0 && timeouts == 0
            && reads_checked > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- flist.f
global_buffer_pkg.sv
glb_cfg_apb_bridge.sv
glb_tile_cfg.sv
glb_cfg_top.sv
tb_clk_gen.sv
tb_cfg_checker.sv
tb_glb_cfg.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns
TOP       ?= tb_glb_cfg
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
